// ==== mem_pkg.sv ====
package mem_pkg;

  // memory geometry
  localparam int addr_w    = 10;
  localparam int data_w    = 8;
  localparam int mem_bytes = 1024;

  // byte address into the program/data RAM
  typedef logic [addr_w-1:0] addr_t;

  // one RAM byte
  typedef logic [data_w-1:0] byte_t;

  // first instruction fetched after reset
  localparam addr_t prog_start = addr_t'(120);

  // hex image loaded into the RAM at time zero
  localparam string mem_init_file = "program.hex";

endpackage

// ==== isa_pkg.sv ====
package isa_pkg;

  localparam int word_w      = 16;
  localparam int reg_idx_w   = 5;
  localparam int num_regs    = 32;
  localparam int instr_bytes = 4;  // opcode, reg, operand hi, operand lo
  localparam int led_w       = 8;

  // opcode byte values
  typedef enum logic [7:0] {
    op_jmp     = 8'd1,  // pc <= operand
    op_ram2reg = 8'd2,  // reg <= ram[operand]
    op_reg2ram = 8'd3,  // ram[operand] <= reg low byte
    op_num2reg = 8'd4   // reg <= operand
  } opcode_e;

  typedef logic [reg_idx_w-1:0] reg_idx_t;
  typedef logic [word_w-1:0]    word_t;
  typedef logic [led_w-1:0]     led_t;

  // sticky flag bits in led
  localparam int led_jmp   = 1;
  localparam int led_load  = 2;
  localparam int led_store = 3;
  localparam int led_num   = 4;

endpackage

// ==== program_ram.sv ====
`timescale 1ns/1ps

module program_ram
  import mem_pkg::*;
(
  input  logic  clk,
  input  logic  rd_en,
  input  addr_t rd_addr,
  input  logic  wr_en,
  input  addr_t wr_addr,
  input  byte_t wr_data,
  output byte_t rd_data
);

  byte_t mem [mem_bytes];

  // program and data image
  initial begin
    $readmemh(mem_init_file, mem);
  end

  // read and write share one edge, a colliding read sees the old byte
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_data <= mem[rd_addr];  // valid the cycle after rd_en
    end
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

endmodule

// ==== register_file.sv ====
`timescale 1ns/1ps

module register_file
  import isa_pkg::*;
(
  input  logic     clk,
  input  reg_idx_t rd_idx,
  input  logic     we,
  input  reg_idx_t wr_idx,
  input  word_t    wr_data,
  output word_t    rd_value
);

  word_t regs [num_regs];  // contents undefined until written

  // combinational read port
  assign rd_value = regs[rd_idx];

  always_ff @(posedge clk) begin
    if (we) begin
      regs[wr_idx] <= wr_data;
    end
  end

endmodule

// ==== fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit
  import mem_pkg::*;
  import isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     fetch_issue,
  input  logic     byte_valid,
  input  logic     jump,
  input  addr_t    jump_target,
  input  byte_t    rd_data,
  output addr_t    pc,
  output opcode_e  opcode,
  output reg_idx_t reg_idx,
  output word_t    operand
);

  localparam int instr_w = instr_bytes * data_w;

  logic [instr_w-1:0] instr;  // byte 0 ends up in the top byte

  // program counter
  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= prog_start;
    end else if (jump) begin
      pc <= jump_target;  // only in the execute cycle, which never overlaps a fetch
    end else if (fetch_issue) begin
      pc <= pc + addr_t'(1);
    end
  end

  // shift returning bytes in from the bottom
  always_ff @(posedge clk) begin
    if (byte_valid) begin
      instr <= {instr[instr_w-data_w-1:0], rd_data};
    end
  end

  // operand is big-endian
  assign opcode  = opcode_e'(instr[instr_w-1 -: data_w]);
  assign reg_idx = instr[instr_w-2*data_w +: reg_idx_w];  // upper bits of byte 1 ignored
  assign operand = instr[word_w-1:0];

endmodule

// ==== cpu_control.sv ====
`timescale 1ns/1ps

module cpu_control
  import mem_pkg::*;
  import isa_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  addr_t    pc,
  input  opcode_e  opcode,
  input  reg_idx_t reg_idx,
  input  word_t    operand,
  input  byte_t    rd_data,
  input  word_t    rd_value,
  // RAM side
  output logic     rd_en,
  output addr_t    rd_addr,
  output logic     wr_en,
  output addr_t    wr_addr,
  output byte_t    wr_data,
  // fetch side
  output logic     fetch_issue,
  output logic     byte_valid,
  output logic     jump,
  output addr_t    jump_target,
  // register side
  output logic     reg_we,
  output reg_idx_t reg_wr_idx,
  output word_t    reg_wr_data,
  output led_t     led
);

  typedef enum logic [2:0] {
    st_fetch,         // one RAM read per instruction byte
    st_fetch_last,    // last byte returning
    st_exec,
    st_load_issue,    // data read for ram2reg
    st_load_capture
  } ctrl_state_e;

  localparam int cnt_w = $clog2(instr_bytes);
  localparam logic [cnt_w-1:0] last_byte = cnt_w'(instr_bytes - 1);

  ctrl_state_e       state;
  logic [cnt_w-1:0]  byte_cnt;
  logic              in_exec;
  addr_t             op_addr;

  assign in_exec = (state == st_exec);
  assign op_addr = operand[addr_w-1:0];  // physical address from low operand bits

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= st_fetch;
      byte_cnt <= '0;
    end else begin
      case (state)
        st_fetch: begin
          if (byte_cnt == last_byte) begin
            byte_cnt <= '0;
            state    <= st_fetch_last;
          end else begin
            byte_cnt <= byte_cnt + 1'b1;
          end
        end
        st_fetch_last: state <= st_exec;
        st_exec: begin
          if (opcode == op_ram2reg) begin
            state <= st_load_issue;
          end else begin
            state <= st_fetch;  // jump target already loaded into pc
          end
        end
        st_load_issue:   state <= st_load_capture;
        st_load_capture: state <= st_fetch;
        default:         state <= st_fetch;
      endcase
    end
  end

  // RAM read port, pc while fetching, operand for loads
  assign rd_en   = (state == st_fetch) || (state == st_load_issue);
  assign rd_addr = (state == st_load_issue) ? op_addr : pc;

  assign fetch_issue = (state == st_fetch);
  assign byte_valid  = ((state == st_fetch) && (byte_cnt != '0)) || (state == st_fetch_last);

  // store strobe from the low byte of the selected register
  assign wr_en   = in_exec && (opcode == op_reg2ram);
  assign wr_addr = op_addr;
  assign wr_data = rd_value[data_w-1:0];

  assign jump        = in_exec && (opcode == op_jmp);
  assign jump_target = op_addr;

  // register write, immediate in exec or loaded byte in capture
  assign reg_we      = (in_exec && (opcode == op_num2reg)) || (state == st_load_capture);
  assign reg_wr_idx  = reg_idx;
  assign reg_wr_data = (state == st_load_capture) ? word_t'(rd_data) : operand;

  // sticky opcode flags
  always_ff @(posedge clk) begin
    if (rst) begin
      led <= '0;
    end else if (in_exec) begin
      case (opcode)
        op_jmp:     led[led_jmp]   <= 1'b1;
        op_ram2reg: led[led_load]  <= 1'b1;
        op_reg2ram: led[led_store] <= 1'b1;
        op_num2reg: led[led_num]   <= 1'b1;
        default:    ;  // unknown opcode is a no-op
      endcase
    end
  end

endmodule

// ==== cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
  import mem_pkg::*;
  import isa_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  output led_t  led,
  output logic  store_strobe,
  output addr_t store_addr,
  output byte_t store_data
);

  logic     rd_en;
  addr_t    rd_addr;
  byte_t    rd_data;
  logic     wr_en;
  addr_t    wr_addr;
  byte_t    wr_data;
  logic     fetch_issue;
  logic     byte_valid;
  logic     jump;
  addr_t    jump_target;
  addr_t    pc;
  opcode_e  opcode;
  reg_idx_t reg_idx;
  word_t    operand;
  word_t    rd_value;
  logic     reg_we;
  reg_idx_t reg_wr_idx;
  word_t    reg_wr_data;

  cpu_control u_control (
    .clk         (clk),
    .rst         (rst),
    .pc          (pc),
    .opcode      (opcode),
    .reg_idx     (reg_idx),
    .operand     (operand),
    .rd_data     (rd_data),
    .rd_value    (rd_value),
    .rd_en       (rd_en),
    .rd_addr     (rd_addr),
    .wr_en       (wr_en),
    .wr_addr     (wr_addr),
    .wr_data     (wr_data),
    .fetch_issue (fetch_issue),
    .byte_valid  (byte_valid),
    .jump        (jump),
    .jump_target (jump_target),
    .reg_we      (reg_we),
    .reg_wr_idx  (reg_wr_idx),
    .reg_wr_data (reg_wr_data),
    .led         (led)
  );

  fetch_unit u_fetch (
    .clk         (clk),
    .rst         (rst),
    .fetch_issue (fetch_issue),
    .byte_valid  (byte_valid),
    .jump        (jump),
    .jump_target (jump_target),
    .rd_data     (rd_data),
    .pc          (pc),
    .opcode      (opcode),
    .reg_idx     (reg_idx),
    .operand     (operand)
  );

  register_file u_regs (
    .clk      (clk),
    .rd_idx   (reg_idx),  // decoded register feeds the store path
    .we       (reg_we),
    .wr_idx   (reg_wr_idx),
    .wr_data  (reg_wr_data),
    .rd_value (rd_value)
  );

  program_ram u_ram (
    .clk     (clk),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_data (rd_data)
  );

  // RAM write bus brought out for observing stores
  assign store_strobe = wr_en;
  assign store_addr   = wr_addr;
  assign store_data   = wr_data;

endmodule

// ==== tb_cpu.sv ====
`timescale 1ns/1ps

module tb_cpu
  import mem_pkg::*;
  import isa_pkg::*;
();

  localparam int clk_period     = 10;
  localparam int input_delay    = 1;
  localparam int reset_cycles   = 4;
  localparam int fetch_cycles   = instr_bytes + 1;  // four issues plus last byte
  localparam int base_len       = fetch_cycles + 1;
  localparam int load_len       = base_len + 2;     // read issue and capture
  localparam int run_instrs     = 40;               // counted after the second reset
  localparam int min_mid_cycles = 40;
  localparam int mid_cycle_span = 150;
  localparam int max_mid_instrs = (min_mid_cycles + mid_cycle_span) / base_len + 1;
  localparam int watchdog_ns    = (max_mid_instrs + run_instrs) * load_len * clk_period * 2
                                  + 2 * reset_cycles * clk_period;
  localparam logic [31:0] rand_seed = 32'h2ef3;

  logic  clk;
  logic  rst;
  led_t  led;
  logic  store_strobe;
  addr_t store_addr;
  byte_t store_data;

  // instruction-set model
  byte_t    m_mem [mem_bytes];
  word_t    m_regs [num_regs];
  addr_t    m_pc;
  led_t     m_led;
  opcode_e  cur_op;
  reg_idx_t cur_reg;
  word_t    cur_operand;
  int       cur_exec;
  int       next_start;
  int       exp_gap;          // cycles back to the previous store
  int       len_since_store;
  int       prev_store_cyc;

  int          cyc;
  logic        prev_rst = 1'b1;  // rst as seen by the last rising edge
  int          exec_count = 0;
  int          store_count = 0;
  int          jump_count = 0;
  int unsigned mid_cycles;

  cpu_top u_dut (
    .clk          (clk),
    .rst          (rst),
    .led          (led),
    .store_strobe (store_strobe),
    .store_addr   (store_addr),
    .store_data   (store_data)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  task automatic abort_run();
    $display("test failed");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic expect_eq(input string name, input logic [31:0] expected,
                           input logic [31:0] actual);
    assert (actual === expected) else begin
      $display("** Error at %0t: %s expected 0x%0h, actual 0x%0h", $time, name, expected,
               actual);
      abort_run();
    end
  endtask

  task automatic hold_reset();
    rst = 1'b1;
    repeat (reset_cycles) @(posedge clk);
    #input_delay;
    rst = 1'b0;
  endtask

  // fetch the next instruction from the model memory
  task automatic decode_next();
    cur_op      = opcode_e'(m_mem[m_pc]);
    cur_reg     = m_mem[addr_t'(m_pc + 1)][reg_idx_w-1:0];
    cur_operand = {m_mem[addr_t'(m_pc + 2)], m_mem[addr_t'(m_pc + 3)]};  // big-endian
    m_pc        = addr_t'(m_pc + instr_bytes);
    cur_exec    = cyc + fetch_cycles;
    next_start  = cyc + ((cur_op == op_ram2reg) ? load_len : base_len);
    if (cur_op == op_reg2ram) begin
      exp_gap         = len_since_store;
      len_since_store = 0;
    end
    len_since_store = len_since_store + (next_start - cyc);
  endtask

  task automatic check_cycle();
    logic  exp_strobe;
    addr_t op_addr;
    byte_t exp_data;
    exp_strobe = (cyc == cur_exec) && (cur_op == op_reg2ram);
    op_addr    = cur_operand[addr_w-1:0];
    exp_data   = m_regs[cur_reg][data_w-1:0];  // truncated to the low byte
    if (cyc < fetch_cycles) begin
      expect_eq("led", '0, led);
      expect_eq("store_strobe", 1'b0, store_strobe);
    end
    // distance between strobes raised by the DUT
    if (store_strobe === 1'b1) begin
      expect_eq("store gap in cycles", exp_gap, cyc - prev_store_cyc);
      prev_store_cyc = cyc;
    end
    expect_eq("store_strobe", exp_strobe, store_strobe);
    expect_eq("led", m_led, led);
    if (exp_strobe) begin
      expect_eq("store_addr", op_addr, store_addr);
      expect_eq("store_data", exp_data, store_data);
      store_count    = store_count + 1;
      m_mem[op_addr] = exp_data;
    end
    if (cyc == cur_exec) begin
      exec_count = exec_count + 1;
      case (cur_op)
        op_jmp: begin
          m_pc             = op_addr;
          m_led[led_jmp]   = 1'b1;
          jump_count       = jump_count + 1;
        end
        op_ram2reg: m_led[led_load] = 1'b1;
        op_reg2ram: m_led[led_store] = 1'b1;
        op_num2reg: begin
          m_regs[cur_reg] = cur_operand;
          m_led[led_num]  = 1'b1;
        end
        default: ;  // no-op leaves led unchanged
      endcase
    end
    // loaded byte lands zero-extended in the capture cycle
    if ((cyc == cur_exec + 2) && (cur_op == op_ram2reg)) begin
      m_regs[cur_reg] = word_t'(m_mem[op_addr]);
    end
  endtask

  // model stepping and checks at mid-cycle
  always @(negedge clk) begin
    if (prev_rst) begin
      cyc = 0;
    end else begin
      cyc = cyc + 1;
    end
    prev_rst = rst;
    if (cyc == 0) begin
      m_pc            = prog_start;
      m_led           = '0;
      next_start      = 0;
      exec_count      = 0;
      store_count     = 0;
      jump_count      = 0;
      len_since_store = 0;
      prev_store_cyc  = fetch_cycles;  // first store gap counts from reset
    end
    if (cyc == next_start) begin
      decode_next();
    end
    check_cycle();
  end

  led_cleared: assert property (@(posedge clk) rst |=> (led == '0))
    else begin
      $display("** Error at %0t: led expected 0x0, actual 0x%0h", $time, $sampled(led));
      abort_run();
    end

  strobe_quiet: assert property (@(posedge clk) rst |=> !store_strobe)
    else begin
      $display("** Error at %0t: store_strobe expected 0, actual %0b", $time,
               $sampled(store_strobe));
      abort_run();
    end

  initial begin
    #(watchdog_ns);
    $display("timeout: the run did not finish within %0d ns", watchdog_ns);
    abort_run();
  end

  initial begin
    rst = 1'b1;
    $readmemh(mem_init_file, m_mem);
    void'($urandom(rand_seed));
    mid_cycles = min_mid_cycles + ($urandom % mid_cycle_span);
    hold_reset();
    repeat (mid_cycles) @(posedge clk);
    #input_delay;
    hold_reset();  // mid-run reset
    wait (exec_count >= run_instrs);
    @(negedge clk);
    assert (jump_count >= 2) else begin
      $display("loop jump ran %0d times after the second reset, at least 2 needed",
               jump_count);
      abort_run();
    end
    assert (store_count >= 8) else begin
      $display("only %0d stores seen after the second reset, at least 8 needed",
               store_count);
      abort_run();
    end
    $display("test passed");
    $finish;
  end

endmodule

// ==== program.hex ====
// program_ram image, one byte per hex pair, @ lines set the byte address
// code lines hold one instruction as opcode, register, operand high, operand low
@078
04 01 12 34  // r1 <= 0x1234
04 02 00 a5  // r2 <= 0x00a5
02 03 03 00  // r3 <= ram[0x300]
03 03 03 10  // ram[0x310] <= r3 low byte
03 01 03 11  // ram[0x311] <= r1 low byte
09 05 ff ff  // unknown opcode, no-op
03 02 03 12  // ram[0x312] <= r2 low byte
01 00 00 c8  // jump to second copy at 0x0c8
@0c8
04 04 be ef  // r4 <= 0xbeef
02 05 03 01  // r5 <= ram[0x301]
03 05 03 20  // ram[0x320] <= r5 low byte
03 04 03 21  // ram[0x321] <= r4 low byte
7f 00 00 00  // unknown opcode, no-op
02 26 03 11  // r6 <= ram[0x311], upper register bits ignored
03 06 03 22  // ram[0x322] <= r6 low byte
01 00 fc c8  // jump to 0x0c8, upper operand bits ignored
@300
c7 5a        // load data bytes

// ==== sources.f ====
mem_pkg.sv
isa_pkg.sv
program_ram.sv
register_file.sv
fetch_unit.sv
cpu_control.sv
cpu_top.sv
tb_cpu.sv

// ==== Makefile ====
# Verilator build and run for the cpu testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= test passed
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing --assert

SRCS := $(shell cat $(FILELIST))
SIM  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

# the simulation reads program.hex from the project root
run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation did not pass, see $(LOG)"; exit 1; }
	@echo "pass message found in $(LOG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
